/* iwm_core.f */
+incdir+include
hdl/iwm_pkg.sv
hdl/iwm_bus_decode.sv
hdl/iwm_soft_switches.sv
hdl/iwm_spin_timer.sv
hdl/iwm_status_read.sv
hdl/iwm_core.sv
dv/iwm_core_assert.sv
dv/iwm_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the iwm_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f iwm_core.f --top-module iwm_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Viwm_core_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
exit 1

/* include/iwm_tb_tasks.svh */
`ifndef IWM_TB_TASKS_SVH
`define IWM_TB_TASKS_SVH

// LCG with a 32-bit state
function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

function automatic iwm_drive_ctrl_t expected_ctrl();
    iwm_drive_ctrl_t c;
    c.phases    = exp_phases;
    c.motor_on  = exp_motor;
    c.drive_sel = exp_dsel;
    c.sense_reg = exp_sense;
    return c;
endfunction

// Status when Q6 on and Q7 off, idle byte otherwise
function automatic logic [7:0] expected_read();
    if (exp_q6 && !exp_q7) begin
        return {exp_motor ? drive_sense : 1'b1, 1'b0, exp_motor, exp_mode};
    end
    return 8'hFF;
endfunction

task automatic compare_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
        $display("FAILED %s: expected %02h, actual %02h", name, exp, act);
        test_errors++;
    end
endtask

task automatic compare_drive_ctrl(input string name, input iwm_drive_ctrl_t exp,
                                  input iwm_drive_ctrl_t act);
    if (act !== exp) begin
        $display("FAILED %s: expected %03h, actual %03h", name, exp, act);
        test_errors++;
    end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("FAILED %s: expected %b, actual %b", name, exp, act);
        test_errors++;
    end
endtask

task automatic finish_test(input string name);
    tests_run++;
    error_count += test_errors;
    $display("%s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "bad", test_errors);
    test_errors = 0;
endtask

// Three-cycle access with PH2 in the middle cycle where outputs are captured
task automatic bus_access(input logic [3:0] a, input logic is_read, input logic [7:0] data);
    logic q6_now;
    logic q7_now;
    q6_now = (a[3:1] == 3'd6) ? a[0] : exp_q6;
    q7_now = (a[3:1] == 3'd7) ? a[0] : exp_q7;
    if (!is_read && !exp_motor && q6_now && q7_now && a[0]) begin
        exp_mode = iwm_mode_t'(data[4:0]);
    end
    case (a[3:1])
        3'd4: exp_motor = a[0];
        3'd5: exp_dsel  = a[0];
        3'd6: exp_q6    = a[0];
        3'd7: exp_q7    = a[0];
        default: begin
            exp_phases[a[2:1]] = a[0];
            exp_sense          = exp_phases[2:0];
        end
    endcase
    @(posedge CLK_14M);
    device_select <= 1'b1;
    wr_cycle      <= is_read;
    addr          <= a;
    d_in          <= data;
    @(posedge CLK_14M);
    ph2 <= 1'b1;
    @(negedge CLK_14M);
    seen_d_out = d_out;
    seen_ctrl  = drive_ctrl;
    @(posedge CLK_14M);
    ph2 <= 1'b0;
    @(posedge CLK_14M);
    device_select <= 1'b0;
endtask

task automatic test_phase_sense();
    for (int i = 0; i < 4; i++) begin
        bus_access(4'(2 * i + 1), 1'b1, 8'h00);
        compare_drive_ctrl("phase_sense", expected_ctrl(), seen_ctrl);
    end
    bus_access(4'h2, 1'b1, 8'h00);
    compare_drive_ctrl("phase_sense", expected_ctrl(), seen_ctrl);
    bus_access(4'h6, 1'b1, 8'h00);
    compare_drive_ctrl("phase_sense", expected_ctrl(), seen_ctrl);
    // Non-phase accesses keep the index
    bus_access(4'h8, 1'b1, 8'h00);
    compare_drive_ctrl("phase_sense", expected_ctrl(), seen_ctrl);
    bus_access(4'hC, 1'b1, 8'h00);
    bus_access(4'hE, 1'b1, 8'h00);
    @(negedge CLK_14M);
    compare_drive_ctrl("phase_sense", expected_ctrl(), drive_ctrl);
    finish_test("phase_sense");
endtask

task automatic test_mode_write();
    logic [31:0] r;
    logic [7:0]  data;
    r    = next_rand();
    data = r[7:0];
    bus_access(4'h8, 1'b1, 8'h00);
    bus_access(4'hD, 1'b1, 8'h00);
    bus_access(4'hF, 1'b0, data);
    bus_access(4'hE, 1'b1, 8'h00);
    compare_byte("mode_write", {3'b100, data[4:0]}, seen_d_out);
    // Motor on blocks the mode write
    bus_access(4'h9, 1'b1, 8'h00);
    bus_access(4'hF, 1'b0, ~data);
    bus_access(4'hE, 1'b1, 8'h00);
    compare_byte("mode_write", {drive_sense, 2'b01, data[4:0]}, seen_d_out);
    bus_access(4'h8, 1'b1, 8'h00);
    finish_test("mode_write");
endtask

task automatic test_status_motor();
    logic [31:0] r;
    bus_access(4'hD, 1'b1, 8'h00);
    for (int i = 0; i < 6; i++) begin
        r = next_rand();
        @(posedge CLK_14M);
        drive_sense <= r[16];
        bus_access((i < 3) ? 4'hD : 4'h9, 1'b1, 8'h00);
        compare_byte("status_motor", expected_read(), seen_d_out);
        compare_drive_ctrl("status_motor", expected_ctrl(), seen_ctrl);
    end
    bus_access(4'hC, 1'b1, 8'h00);
    compare_byte("status_motor", 8'hFF, seen_d_out);
    bus_access(4'hF, 1'b1, 8'h00);
    compare_byte("status_motor", 8'hFF, seen_d_out);
    bus_access(4'hD, 1'b1, 8'h00);
    compare_byte("status_motor", 8'hFF, seen_d_out);
    bus_access(4'hE, 1'b1, 8'h00);
    bus_access(4'h8, 1'b1, 8'h00);
    finish_test("status_motor");
endtask

// Level changes between two PH2 pulses of one access
task automatic test_once_per_access();
    exp_dsel = 1'b1;
    @(posedge CLK_14M);
    device_select <= 1'b1;
    wr_cycle      <= 1'b1;
    addr          <= 4'hB;
    @(posedge CLK_14M);
    ph2 <= 1'b1;
    @(posedge CLK_14M);
    ph2  <= 1'b0;
    addr <= 4'hA;
    @(posedge CLK_14M);
    ph2 <= 1'b1;
    @(posedge CLK_14M);
    ph2 <= 1'b0;
    @(posedge CLK_14M);
    device_select <= 1'b0;
    @(negedge CLK_14M);
    compare_drive_ctrl("once_per_access", expected_ctrl(), drive_ctrl);
    bus_access(4'hA, 1'b1, 8'h00);
    finish_test("once_per_access");
endtask

task automatic test_spin_timer();
    repeat (70) @(posedge CLK_14M);
    bus_access(4'h9, 1'b1, 8'h00);
    repeat (20) @(posedge CLK_14M);
    @(negedge CLK_14M);
    compare_bit("spin_timer", 1'b0, floppy_motor_on);
    repeat (25) @(posedge CLK_14M);
    @(negedge CLK_14M);
    compare_bit("spin_timer", 1'b1, floppy_motor_on);
    bus_access(4'h8, 1'b1, 8'h00);
    repeat (30) @(posedge CLK_14M);
    @(negedge CLK_14M);
    compare_bit("spin_timer", 1'b1, floppy_motor_on);
    repeat (35) @(posedge CLK_14M);
    @(negedge CLK_14M);
    compare_bit("spin_timer", 1'b0, floppy_motor_on);
    // 3.5-inch drive
    @(posedge CLK_14M);
    disk_35 <= 1'b1;
    bus_access(4'h9, 1'b1, 8'h00);
    repeat (50) @(posedge CLK_14M);
    @(negedge CLK_14M);
    compare_bit("spin_timer", 1'b0, floppy_motor_on);
    bus_access(4'h8, 1'b1, 8'h00);
    @(posedge CLK_14M);
    disk_35 <= 1'b0;
    finish_test("spin_timer");
endtask

`endif

/* dv/iwm_core_tb.sv */
`timescale 1ns/1ps

module iwm_core_tb;

    import iwm_pkg::*;

    // About four times the summed length of the directed tests
    localparam int TIMEOUT_CYCLES = 2000;

    logic            CLK_14M;
    logic            RESET;
    logic            ph2;
    logic            device_select;
    logic            wr_cycle;
    logic [3:0]      addr;
    logic [7:0]      d_in;
    logic [7:0]      d_out;
    logic            disk_35;
    logic            drive_sense;
    iwm_drive_ctrl_t drive_ctrl;
    logic            floppy_motor_on;

    // ==========================================================================
    // Reference model of the switch state
    // ==========================================================================

    logic [3:0] exp_phases;
    logic       exp_motor;
    logic       exp_dsel;
    logic       exp_q6;
    logic       exp_q7;
    logic [2:0] exp_sense;
    iwm_mode_t  exp_mode;

    // Outputs captured in the update cycle of the last access
    logic [7:0]      seen_d_out;
    iwm_drive_ctrl_t seen_ctrl;

    logic [31:0] lcg_state;
    int          error_count;
    int          test_errors;
    int          tests_run;
    int          cycle_count;

    iwm_core #(
        .SPINUP_CYCLES   (40),
        .SPINDOWN_CYCLES (60)
    ) iwm_core_inst (
        .CLK_14M         (CLK_14M),
        .RESET           (RESET),
        .ph2             (ph2),
        .device_select   (device_select),
        .wr_cycle        (wr_cycle),
        .addr            (addr),
        .d_in            (d_in),
        .d_out           (d_out),
        .disk_35         (disk_35),
        .drive_sense     (drive_sense),
        .drive_ctrl      (drive_ctrl),
        .floppy_motor_on (floppy_motor_on)
    );

    `include "iwm_tb_tasks.svh"

    // 40 ns period
    initial begin
        CLK_14M = 1'b0;
        forever #20 CLK_14M = ~CLK_14M;
    end

    // Run limit
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge CLK_14M);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("SOME TESTS FAILED");
                $finish;
            end
        end
    end

    initial begin
        RESET         = 1'b1;
        ph2           = 1'b0;
        device_select = 1'b0;
        wr_cycle      = 1'b1;
        addr          = 4'h0;
        d_in          = 8'h00;
        disk_35       = 1'b0;
        drive_sense   = 1'b0;
        exp_phases    = 4'b0000;
        exp_motor     = 1'b0;
        exp_dsel      = 1'b0;
        exp_q6        = 1'b0;
        exp_q7        = 1'b0;
        exp_sense     = 3'b000;
        exp_mode      = '0;
        lcg_state     = 32'd27;
        error_count   = 0;
        tests_run     = 0;
        repeat (10) @(posedge CLK_14M);
        RESET <= 1'b0;
        @(posedge CLK_14M);

        test_phase_sense();
        test_mode_write();
        test_status_motor();
        test_once_per_access();
        test_spin_timer();

        $display("%0d tests run, %0d errors", tests_run, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* dv/iwm_core_assert.sv */
`timescale 1ns/1ps

module iwm_core_assert (
    input logic                       CLK_14M,
    input logic                       RESET,
    input logic                       device_select,
    input logic                       disk_35,
    input logic                       floppy_motor_on,
    input logic [7:0]                 d_out,
    input iwm_pkg::iwm_switch_state_t state,
    input iwm_pkg::iwm_switch_state_t imm
);

    import iwm_pkg::*;

    // Switch registers without the mode register
    logic [7:0] switches;
    logic [7:0] switches_q;
    // A switch already changed during the current access
    logic       changed_in_access;

    assign switches = {state.phases, state.motor_on, state.drive_sel, state.q6, state.q7};

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            switches_q        <= '0;
            changed_in_access <= 1'b0;
        end else begin
            switches_q <= switches;
            if (!device_select) begin
                changed_in_access <= 1'b0;
            end else if (switches != switches_q) begin
                changed_in_access <= 1'b1;
            end
        end
    end

    // 3.5-inch drive with motor held on never shows inertia
    assert property (@(posedge CLK_14M) disable iff (RESET)
        ($past(disk_35 && state.motor_on) && disk_35 && state.motor_on) |-> !floppy_motor_on)
        else $error("motor output high in 3.5-inch mode");

    // Idle byte outside status mode
    assert property (@(posedge CLK_14M) disable iff (RESET)
        !(imm.q6 && !imm.q7) |-> (d_out == 8'hFF))
        else $error("read data not idle outside status mode");

    // One switch per access
    assert property (@(posedge CLK_14M) disable iff (RESET)
        (switches != switches_q) |->
            (($countones(switches ^ switches_q) == 1) && !changed_in_access))
        else $error("more than one switch changed in one access");

endmodule

bind iwm_core iwm_core_assert iwm_core_assert_inst (
    .CLK_14M         (CLK_14M),
    .RESET           (RESET),
    .device_select   (device_select),
    .disk_35         (disk_35),
    .floppy_motor_on (floppy_motor_on),
    .d_out           (d_out),
    .state           (state),
    .imm             (imm)
);

/* hdl/iwm_core.sv */
`timescale 1ns/1ps

module iwm_core #(
    parameter int unsigned SPINUP_CYCLES   = iwm_pkg::SPINUP_CYCLES_DEFAULT,
    parameter int unsigned SPINDOWN_CYCLES = iwm_pkg::SPINDOWN_CYCLES_DEFAULT
) (
    input  logic                     CLK_14M,
    input  logic                     RESET,
    // CPU bus
    input  logic                     ph2,
    input  logic                     device_select,
    input  logic                     wr_cycle,
    input  logic [3:0]               addr,
    input  logic [7:0]               d_in,
    output logic [7:0]               d_out,
    // Drive side
    input  logic                     disk_35,
    input  logic                     drive_sense,
    output iwm_pkg::iwm_drive_ctrl_t drive_ctrl,
    output logic                     floppy_motor_on
);

    import iwm_pkg::*;

    iwm_access_t       access;
    // Registered and same-cycle switch views
    iwm_switch_state_t state;
    iwm_switch_state_t imm;

    iwm_bus_decode bus_decode_inst (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .ph2           (ph2),
        .device_select (device_select),
        .wr_cycle      (wr_cycle),
        .addr          (addr),
        .access        (access)
    );

    iwm_soft_switches soft_switches_inst (
        .CLK_14M    (CLK_14M),
        .RESET      (RESET),
        .access     (access),
        .d_in       (d_in),
        .state      (state),
        .imm        (imm),
        .drive_ctrl (drive_ctrl)
    );

    // Inertia follows the registered motor command
    iwm_spin_timer #(
        .SPINUP_CYCLES   (SPINUP_CYCLES),
        .SPINDOWN_CYCLES (SPINDOWN_CYCLES)
    ) spin_timer_inst (
        .CLK_14M  (CLK_14M),
        .RESET    (RESET),
        .motor_on (state.motor_on),
        .disk_35  (disk_35),
        .spinning (floppy_motor_on)
    );

    iwm_status_read status_read_inst (
        .access      (access),
        .imm         (imm),
        .drive_sense (drive_sense),
        .d_out       (d_out)
    );

endmodule

/* hdl/iwm_status_read.sv */
`timescale 1ns/1ps

module iwm_status_read (
    input  iwm_pkg::iwm_access_t       access,
    input  iwm_pkg::iwm_switch_state_t imm,
    input  logic                       drive_sense,
    output logic [7:0]                 d_out
);

    import iwm_pkg::*;

    iwm_status_t status;
    logic        status_mode;

    always_comb begin
        // No selected drive while the motor is off, sense reads high
        status.sense = imm.motor_on ? drive_sense : 1'b1;
        status.zero  = 1'b0;
        status.motor = imm.motor_on;
        status.mode  = imm.mode;
    end

    // Q6 on, Q7 off selects the status register
    // Write cycles put no read data on the bus
    assign status_mode = imm.q6 && !imm.q7 && !access.wr;

    assign d_out = status_mode ? status : IDLE_READ_BYTE;

endmodule

/* hdl/iwm_spin_timer.sv */
`timescale 1ns/1ps

module iwm_spin_timer #(
    parameter int unsigned SPINUP_CYCLES   = iwm_pkg::SPINUP_CYCLES_DEFAULT,
    parameter int unsigned SPINDOWN_CYCLES = iwm_pkg::SPINDOWN_CYCLES_DEFAULT
) (
    input  logic CLK_14M,
    input  logic RESET,
    input  logic motor_on,
    input  logic disk_35,
    output logic spinning
);

    import iwm_pkg::*;

    localparam logic [SPIN_COUNT_W-1:0] SPINUP_MAX   = SPIN_COUNT_W'(SPINUP_CYCLES);
    localparam logic [SPIN_COUNT_W-1:0] SPINDOWN_MAX = SPIN_COUNT_W'(SPINDOWN_CYCLES);

    logic [SPIN_COUNT_W-1:0] count;
    // Spin-up finished for the current motor-on period
    logic                    spun_up;

    // ==========================================================================
    // 5.25-inch inertia
    // ==========================================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            count    <= '0;
            spun_up  <= 1'b0;
            spinning <= 1'b0;
        end else if (motor_on) begin
            if (disk_35) begin
                // 3.5-inch drive spins on its own
                spinning <= 1'b0;
            end else if (!spun_up) begin
                if (count >= SPINUP_MAX) begin
                    spinning <= 1'b1;
                    spun_up  <= 1'b1;
                    count    <= SPINDOWN_MAX;
                end else begin
                    count <= count + 1'b1;
                end
            end else begin
                // Up to speed, spin-down time kept preloaded
                spinning <= 1'b1;
                count    <= SPINDOWN_MAX;
            end
        end else begin
            // Motor command off, coast down
            spun_up <= 1'b0;
            if (count != '0) begin
                count <= count - 1'b1;
            end else begin
                spinning <= 1'b0;
            end
        end
    end

endmodule

/* hdl/iwm_soft_switches.sv */
`timescale 1ns/1ps

module iwm_soft_switches (
    input  logic                       CLK_14M,
    input  logic                       RESET,
    input  iwm_pkg::iwm_access_t       access,
    input  logic [7:0]                 d_in,
    output iwm_pkg::iwm_switch_state_t state,
    output iwm_pkg::iwm_switch_state_t imm,
    output iwm_pkg::iwm_drive_ctrl_t   drive_ctrl
);

    import iwm_pkg::*;

    // Sense-register index, latched on phase accesses
    logic [2:0] sense_idx;
    logic [2:0] imm_sense;

    logic phase_access;
    logic imm_q6;
    logic imm_q7;
    logic mode_write;

    // ==========================================================================
    // Immediate views
    // ==========================================================================

    assign phase_access = access.active &&
        (access.sel inside {sw_phase0, sw_phase1, sw_phase2, sw_phase3});

    // Q6 and Q7 follow the presented address even before the access
    assign imm_q6 = (access.sel == sw_q6) ? access.level : state.q6;
    assign imm_q7 = (access.sel == sw_q7) ? access.level : state.q7;

    // Mode write needs motor off with immediate Q6 and Q7 both on
    assign mode_write = access.wr && !state.motor_on && imm_q6 && imm_q7 &&
                        access.level;

    always_comb begin
        imm = state;
        for (int i = 0; i < 4; i++) begin
            if (phase_access && (access.sel[1:0] == 2'(i))) begin
                imm.phases[i] = access.level;
            end
        end
        if (access.active && (access.sel == sw_motor)) begin
            imm.motor_on = access.level;
        end
        if (access.active && (access.sel == sw_drive_sel)) begin
            imm.drive_sel = access.level;
        end
        imm.q6 = imm_q6;
        imm.q7 = imm_q7;
        // Incoming mode shows up during the write itself
        if (mode_write) begin
            imm.mode = iwm_mode_t'(d_in[4:0]);
        end
    end

    // Drive sees the new phases as its register index right away
    assign imm_sense = phase_access ? imm.phases[2:0] : sense_idx;

    always_comb begin
        drive_ctrl.phases    = imm.phases;
        drive_ctrl.motor_on  = imm.motor_on;
        drive_ctrl.drive_sel = imm.drive_sel;
        drive_ctrl.sense_reg = imm_sense;
    end

    // ==========================================================================
    // Registered switches
    // ==========================================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            state     <= '0;
            sense_idx <= 3'b000;
        end else if (access.update) begin
            case (access.sel)
                sw_phase0,
                sw_phase1,
                sw_phase2,
                sw_phase3:    state.phases[access.sel[1:0]] <= access.level;
                sw_motor:     state.motor_on  <= access.level;
                sw_drive_sel: state.drive_sel <= access.level;
                sw_q6:        state.q6        <= access.level;
                sw_q7:        state.q7        <= access.level;
            endcase
            // Set or clear of any phase reloads the index
            if (phase_access) begin
                sense_idx <= imm.phases[2:0];
            end
            if (mode_write) begin
                state.mode <= iwm_mode_t'(d_in[4:0]);
            end
        end
    end

endmodule

/* hdl/iwm_bus_decode.sv */
`timescale 1ns/1ps

module iwm_bus_decode (
    input  logic                 CLK_14M,
    input  logic                 RESET,
    input  logic                 ph2,
    input  logic                 device_select,
    input  logic                 wr_cycle,
    input  logic [3:0]           addr,
    output iwm_pkg::iwm_access_t access
);

    import iwm_pkg::*;

    // Set once the current access has been acted on
    logic access_latched;

    always_comb begin
        // wr_cycle high means a read cycle
        access.rd     = device_select && wr_cycle;
        access.wr     = device_select && !wr_cycle;
        access.active = device_select;
        // First PH2 cycle of the access only
        access.update = device_select && ph2 && !access_latched;
        // Switch pair and new level
        access.sel    = iwm_switch_e'(addr[3:1]);
        access.level  = addr[0];
    end

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            access_latched <= 1'b0;
        end else if (!device_select) begin
            // Access over, arm for the next one
            access_latched <= 1'b0;
        end else if (access.update) begin
            access_latched <= 1'b1;
        end
    end

endmodule

/* hdl/iwm_pkg.sv */
package iwm_pkg;

    // ==========================================================================
    // Constants
    // ==========================================================================

    // Read data outside status mode
    localparam logic [7:0] IDLE_READ_BYTE = 8'hFF;

    // Motor inertia counter in 14 MHz cycles
    localparam int unsigned SPIN_COUNT_W            = 24;
    localparam int unsigned SPINUP_CYCLES_DEFAULT   = 4200000;
    localparam int unsigned SPINDOWN_CYCLES_DEFAULT = 14000000;

    // ==========================================================================
    // Types
    // ==========================================================================

    // Switch pair index, taken from addr[3:1]
    typedef enum logic [2:0] {
        sw_phase0    = 3'd0,
        sw_phase1    = 3'd1,
        sw_phase2    = 3'd2,
        sw_phase3    = 3'd3,
        sw_motor     = 3'd4,
        sw_drive_sel = 3'd5,
        sw_q6        = 3'd6,
        sw_q7        = 3'd7
    } iwm_switch_e;

    // Decoded CPU access
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic        active;
        logic        update;
        iwm_switch_e sel;
        logic        level;
    } iwm_access_t;

    // Mode register from bit 4 down to bit 0
    typedef struct packed {
        logic clk_8m;
        logic fast;
        logic timer_off;
        logic async;
        logic latch;
    } iwm_mode_t;

    typedef struct packed {
        logic [3:0] phases;
        logic       motor_on;
        logic       drive_sel;
        logic       q6;
        logic       q7;
        iwm_mode_t  mode;
    } iwm_switch_state_t;

    // Signals seen by the selected drive
    typedef struct packed {
        logic [3:0] phases;
        logic       motor_on;
        logic       drive_sel;
        logic [2:0] sense_reg;
    } iwm_drive_ctrl_t;

    // Status byte layout
    typedef struct packed {
        logic      sense;
        logic      zero;
        logic      motor;
        iwm_mode_t mode;
    } iwm_status_t;

endpackage
